/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	localparam word_t RESET_PC = '0;

	// Major opcodes
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;

	// Branch conditions
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND
	} alu_op_t;

endpackage

/* hw/rv_pipe_pkg.sv */
package rv_pipe_pkg;

	import rv_isa_pkg::*;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		word_t pc;
		word_t rs1_val;
		word_t rs2_val;
		word_t imm;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		alu_op_t alu_op;
		logic use_imm;
		// Operand A from the PC instead of rs1
		logic use_pc;
		logic write_reg;
		logic mem_read;
		logic mem_write;
		logic is_branch;
		logic is_jal;
		logic is_jalr;
		logic [2:0] branch_f3;
	} id_ex_t;

	typedef struct packed {
		word_t alu_res;
		word_t store_data;
		reg_idx_t rd;
		logic write_reg;
		logic mem_read;
		logic mem_write;
	} ex_mem_t;

	typedef struct packed {
		word_t wb_data;
		reg_idx_t rd;
		logic write_reg;
	} mem_wb_t;

	// Source of an execute operand
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

endpackage

/* hw/pipe_stage_reg.sv */
`timescale 1ns/1ns

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic flush,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			out_valid <= 1'b0;
		end else if (!hold) begin
			out_valid <= in_valid;
		end
	end

	// Payload only matters while valid
	always_ff @(posedge clk) begin
		if (!hold) begin
			out_data <= in_data;
		end
	end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect_req,
	input rv_isa_pkg::word_t redirect_pc,
	output rv_isa_pkg::word_t imem_addr,
	input rv_isa_pkg::word_t imem_data,
	output rv_pipe_pkg::if_id_t out,
	output logic out_valid
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	word_t pc;

	// Redirect wins over a load-use stall
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (redirect_req) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc + 32'd4;
		end
	end

	assign imem_addr = pc;

	assign out.pc = pc;
	assign out.instr = imem_data;

	// Wrong-path fetch while execute redirects
	assign out_valid = !redirect_req;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
	input logic clk,
	input logic reset,
	input rv_isa_pkg::reg_idx_t rs1,
	input rv_isa_pkg::reg_idx_t rs2,
	output rv_isa_pkg::word_t rs1_val,
	output rv_isa_pkg::word_t rs2_val,
	input rv_isa_pkg::reg_idx_t rd,
	input rv_isa_pkg::word_t wr_data,
	input logic wr_en
);

	import rv_isa_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && rd != '0) begin
			regs[rd] <= wr_data;
		end
	end

	// Write-through so decode sees the write-back value
	assign rs1_val = (rs1 == '0) ? '0 : (wr_en && rd == rs1) ? wr_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (wr_en && rd == rs2) ? wr_data : regs[rs2];

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
	input rv_pipe_pkg::if_id_t in,
	output rv_isa_pkg::reg_idx_t rs1,
	output rv_isa_pkg::reg_idx_t rs2,
	input rv_isa_pkg::word_t rs1_val,
	input rv_isa_pkg::word_t rs2_val,
	output rv_pipe_pkg::id_ex_t out
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	logic no_rs1;
	logic no_rd;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	// alt selects SUB or SRA
	function automatic alu_op_t alu_decode(logic [2:0] code, logic alt);
		case (code)
			3'b000: return alt ? SUB : ADD;
			3'b001: return SLL;
			3'b010: return SLT;
			3'b011: return SLTU;
			3'b100: return XOR;
			3'b101: return alt ? SRA : SRL;
			3'b110: return OR;
			default: return AND;
		endcase
	endfunction

	assign opcode = in.instr[6:0];
	assign f3 = in.instr[14:12];
	assign f7 = in.instr[31:25];

	assign no_rs1 = (opcode == OP_LUI) || (opcode == OP_AUIPC) || (opcode == OP_JAL);
	assign no_rd = (opcode == OP_STORE) || (opcode == OP_BRANCH);

	assign rs1 = no_rs1 ? '0 : in.instr[19:15];
	assign rs2 = in.instr[24:20];

	assign imm_i = {{20{in.instr[31]}}, in.instr[31:20]};
	assign imm_s = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
	assign imm_b = {{19{in.instr[31]}}, in.instr[31], in.instr[7],
		in.instr[30:25], in.instr[11:8], 1'b0};
	assign imm_u = {in.instr[31:12], 12'b0};
	assign imm_j = {{11{in.instr[31]}}, in.instr[31], in.instr[19:12],
		in.instr[20], in.instr[30:21], 1'b0};

	always_comb begin
		out = '0;
		out.pc = in.pc;
		out.rs1_val = rs1_val;
		out.rs2_val = rs2_val;
		out.rs1 = rs1;
		out.rs2 = rs2;
		out.rd = no_rd ? '0 : in.instr[11:7];
		out.alu_op = ADD;
		out.branch_f3 = f3;
		case (opcode)
			OP_LUI: begin
				out.imm = imm_u;
				out.use_imm = 1'b1;
				out.write_reg = 1'b1;
			end
			OP_AUIPC: begin
				out.imm = imm_u;
				out.use_imm = 1'b1;
				out.use_pc = 1'b1;
				out.write_reg = 1'b1;
			end
			OP_JAL: begin
				out.imm = imm_j;
				out.use_pc = 1'b1;
				out.is_jal = 1'b1;
				out.write_reg = 1'b1;
			end
			OP_JALR: begin
				out.imm = imm_i;
				out.is_jalr = 1'b1;
				out.write_reg = 1'b1;
			end
			OP_BRANCH: begin
				out.imm = imm_b;
				out.is_branch = 1'b1;
			end
			OP_LOAD: begin
				out.imm = imm_i;
				out.use_imm = 1'b1;
				out.mem_read = 1'b1;
				out.write_reg = 1'b1;
			end
			OP_STORE: begin
				out.imm = imm_s;
				out.use_imm = 1'b1;
				out.mem_write = 1'b1;
			end
			OP_IMM: begin
				out.imm = imm_i;
				out.use_imm = 1'b1;
				out.write_reg = 1'b1;
				// funct7 only qualifies the shift
				out.alu_op = alu_decode(f3, (f3 == 3'b101) && f7[5]);
			end
			OP_REG: begin
				out.write_reg = 1'b1;
				out.alu_op = alu_decode(f3, f7[5]);
			end
			default: begin
				out.rd = '0;
			end
		endcase
	end

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
	input rv_isa_pkg::reg_idx_t id_rs1,
	input rv_isa_pkg::reg_idx_t id_rs2,
	input rv_isa_pkg::reg_idx_t ex_rs1,
	input rv_isa_pkg::reg_idx_t ex_rs2,
	input rv_isa_pkg::reg_idx_t ex_rd,
	input logic ex_mem_read,
	input logic ex_valid,
	input rv_isa_pkg::reg_idx_t mem_rd,
	input logic mem_write_reg,
	input logic mem_valid,
	input rv_isa_pkg::reg_idx_t wb_rd,
	input logic wb_write_reg,
	input logic wb_valid,
	input logic redirect_req,
	output logic stall,
	output logic redirect,
	output rv_pipe_pkg::fwd_sel_t fwd_a,
	output rv_pipe_pkg::fwd_sel_t fwd_b
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	// Memory stage holds the younger writer
	function automatic fwd_sel_t pick(reg_idx_t src);
		if (src == '0) begin
			return FWD_NONE;
		end
		if (mem_valid && mem_write_reg && mem_rd == src) begin
			return FWD_MEM;
		end
		if (wb_valid && wb_write_reg && wb_rd == src) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	always_comb begin
		fwd_a = pick(ex_rs1);
		fwd_b = pick(ex_rs2);
	end

	// Load data is only ready in write-back, one bubble covers it
	assign stall = ex_valid && ex_mem_read && (ex_rd != '0) &&
		(ex_rd == id_rs1 || ex_rd == id_rs2);

	assign redirect = redirect_req;

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
	input rv_pipe_pkg::id_ex_t in,
	input rv_pipe_pkg::fwd_sel_t fwd_a,
	input rv_pipe_pkg::fwd_sel_t fwd_b,
	input rv_isa_pkg::word_t mem_fwd,
	input rv_isa_pkg::word_t wb_fwd,
	output rv_pipe_pkg::ex_mem_t out,
	output logic redirect_req,
	output rv_isa_pkg::word_t redirect_pc,
	input logic in_valid
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	word_t src_a;
	word_t src_b;
	word_t op_a;
	word_t op_b;
	word_t alu_out;
	word_t jalr_target;
	logic taken;

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
		word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign src_a = fwd_mux(fwd_a, in.rs1_val, mem_fwd, wb_fwd);
	assign src_b = fwd_mux(fwd_b, in.rs2_val, mem_fwd, wb_fwd);

	assign op_a = in.use_pc ? in.pc : src_a;
	assign op_b = in.use_imm ? in.imm : src_b;

	always_comb begin
		case (in.alu_op)
			SUB: alu_out = op_a - op_b;
			SLL: alu_out = op_a << op_b[4:0];
			SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			SLTU: alu_out = {31'b0, op_a < op_b};
			XOR: alu_out = op_a ^ op_b;
			SRL: alu_out = op_a >> op_b[4:0];
			SRA: alu_out = $signed(op_a) >>> op_b[4:0];
			OR: alu_out = op_a | op_b;
			AND: alu_out = op_a & op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	always_comb begin
		case (in.branch_f3)
			F3_BEQ: taken = (src_a == src_b);
			F3_BNE: taken = (src_a != src_b);
			F3_BLT: taken = ($signed(src_a) < $signed(src_b));
			F3_BGE: taken = ($signed(src_a) >= $signed(src_b));
			F3_BLTU: taken = (src_a < src_b);
			F3_BGEU: taken = (src_a >= src_b);
			default: taken = 1'b0;
		endcase
	end

	assign jalr_target = (src_a + in.imm) & ~32'd1;
	assign redirect_pc = in.is_jalr ? jalr_target : in.pc + in.imm;
	assign redirect_req = in_valid && (in.is_jal || in.is_jalr || (in.is_branch && taken));

	always_comb begin
		// Jumps write the return address
		out.alu_res = (in.is_jal || in.is_jalr) ? in.pc + 32'd4 : alu_out;
		out.store_data = src_b;
		out.rd = in.rd;
		out.write_reg = in.write_reg;
		out.mem_read = in.mem_read;
		out.mem_write = in.mem_write;
	end

endmodule

/* hw/mem_wb_stage.sv */
`timescale 1ns/1ns

module mem_wb_stage (
	input rv_pipe_pkg::ex_mem_t in,
	input logic in_valid,
	output rv_isa_pkg::word_t dmem_addr,
	output rv_isa_pkg::word_t dmem_wdata,
	output logic dmem_we,
	output logic dmem_re,
	input rv_isa_pkg::word_t dmem_rdata,
	output rv_pipe_pkg::mem_wb_t out
);

	import rv_pipe_pkg::*;

	assign dmem_addr = in.alu_res;
	assign dmem_wdata = in.store_data;

	// Bubbles and flushed slots never touch memory
	assign dmem_we = in_valid && in.mem_write;
	assign dmem_re = in_valid && in.mem_read;

	always_comb begin
		out.wb_data = in.mem_read ? dmem_rdata : in.alu_res;
		out.rd = in.rd;
		out.write_reg = in.write_reg;
	end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
	input logic clk,
	input logic reset,
	output rv_isa_pkg::word_t imem_addr,
	input rv_isa_pkg::word_t imem_data,
	output rv_isa_pkg::word_t dmem_addr,
	output rv_isa_pkg::word_t dmem_wdata,
	output logic dmem_we,
	output logic dmem_re,
	input rv_isa_pkg::word_t dmem_rdata
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	if_id_t fetch_out;
	if_id_t if_id;
	id_ex_t decode_out;
	id_ex_t id_ex;
	ex_mem_t exec_out;
	ex_mem_t ex_mem;
	mem_wb_t mem_out;
	mem_wb_t mem_wb;
	logic fetch_valid;
	logic if_id_valid;
	logic id_ex_valid;
	logic ex_mem_valid;
	logic mem_wb_valid;
	reg_idx_t id_rs1;
	reg_idx_t id_rs2;
	word_t rs1_val;
	word_t rs2_val;
	logic stall;
	logic redirect;
	logic redirect_req;
	word_t redirect_pc;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	fetch_stage u_fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect_req(redirect_req),
		.redirect_pc(redirect_pc),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.out(fetch_out),
		.out_valid(fetch_valid)
	);

	pipe_stage_reg #(.payload_t(if_id_t)) u_if_id (
		.clk(clk),
		.reset(reset),
		.hold(stall),
		.flush(redirect),
		.in_valid(fetch_valid),
		.in_data(fetch_out),
		.out_valid(if_id_valid),
		.out_data(if_id)
	);

	decode_stage u_decode (
		.in(if_id),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.out(decode_out)
	);

	reg_file u_regs (
		.clk(clk),
		.reset(reset),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.rd(mem_wb.rd),
		.wr_data(mem_wb.wb_data),
		.wr_en(mem_wb_valid && mem_wb.write_reg)
	);

	// A stall turns the decode slot into a bubble
	pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(stall || redirect),
		.in_valid(if_id_valid),
		.in_data(decode_out),
		.out_valid(id_ex_valid),
		.out_data(id_ex)
	);

	execute_stage u_execute (
		.in(id_ex),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.mem_fwd(ex_mem.alu_res),
		.wb_fwd(mem_wb.wb_data),
		.out(exec_out),
		.redirect_req(redirect_req),
		.redirect_pc(redirect_pc),
		.in_valid(id_ex_valid)
	);

	pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(1'b0),
		.in_valid(id_ex_valid),
		.in_data(exec_out),
		.out_valid(ex_mem_valid),
		.out_data(ex_mem)
	);

	mem_wb_stage u_mem (
		.in(ex_mem),
		.in_valid(ex_mem_valid),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_re(dmem_re),
		.dmem_rdata(dmem_rdata),
		.out(mem_out)
	);

	pipe_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(1'b0),
		.in_valid(ex_mem_valid),
		.in_data(mem_out),
		.out_valid(mem_wb_valid),
		.out_data(mem_wb)
	);

	hazard_unit u_hazard (
		.id_rs1(id_rs1),
		.id_rs2(id_rs2),
		.ex_rs1(id_ex.rs1),
		.ex_rs2(id_ex.rs2),
		.ex_rd(id_ex.rd),
		.ex_mem_read(id_ex.mem_read),
		.ex_valid(id_ex_valid),
		.mem_rd(ex_mem.rd),
		.mem_write_reg(ex_mem.write_reg),
		.mem_valid(ex_mem_valid),
		.wb_rd(mem_wb.rd),
		.wb_write_reg(mem_wb.write_reg),
		.wb_valid(mem_wb_valid),
		.redirect_req(redirect_req),
		.stall(stall),
		.redirect(redirect),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

endmodule

/* verification/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;

	import rv_isa_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int PROG_WORDS = 12;
	localparam int MAX_STORES = 4;
	// jal x0, 0
	localparam word_t HALT = 32'h0000006f;
	// sw x0, 60(x0), fetched while reset is applied
	localparam word_t STRAY_STORE = 32'h02002e23;

	logic clk;
	logic reset;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic dmem_we;
	logic dmem_re;
	word_t dmem_rdata;

	word_t imem [16];
	word_t dmem [64];
	word_t log_addr [$];
	word_t log_data [$];
	int reset_writes;
	int read_count;

	string test_name [NUM_TESTS];
	word_t prog [NUM_TESTS][PROG_WORDS];
	word_t exp_addr [NUM_TESTS][MAX_STORES];
	word_t exp_data [NUM_TESTS][MAX_STORES];
	int exp_count [NUM_TESTS];
	int exp_reads [NUM_TESTS];
	int budget [NUM_TESTS];

	int errors;
	int test_errors;
	int passed;
	int watchdog_ns;

	rv_core dut (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_re(dmem_re),
		.dmem_rdata(dmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fetch past the program spins on a self-loop
	assign imem_data = (imem_addr < 32'd64) ? imem[imem_addr[5:2]] : HALT;
	assign dmem_rdata = dmem[dmem_addr[7:2]];

	// Sampled at the edge, before the core updates
	always @(posedge clk) begin
		if (reset) begin
			if (dmem_we !== 1'b0) begin
				reset_writes = reset_writes + 1;
			end
		end else begin
			if (dmem_we) begin
				log_addr.push_back(dmem_addr);
				log_data.push_back(dmem_wdata);
				dmem[dmem_addr[7:2]] <= dmem_wdata;
			end
			if (dmem_re) begin
				read_count = read_count + 1;
			end
		end
	end

	function automatic word_t dmem_fill(word_t addr);
		return 32'hc0de0000 ^ addr;
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			$display("Wrong %s: saw %0d, expected %0d", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic expect_store(int t, word_t addr, word_t data);
		exp_addr[t][exp_count[t]] = addr;
		exp_data[t][exp_count[t]] = data;
		exp_count[t]++;
	endtask

	task automatic build_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			exp_count[t] = 0;
			exp_reads[t] = 0;
			for (int i = 0; i < PROG_WORDS; i++) begin
				prog[t][i] = HALT;
			end
		end
		test_name[0] = "alu forwarding";
		budget[0] = 30;
		prog[0][0] = 32'h00500093; // addi x1, x0, 5
		prog[0][1] = 32'hffd00113; // addi x2, x0, -3
		prog[0][2] = 32'h002081b3; // add  x3, x1, x2
		prog[0][3] = 32'h40208233; // sub  x4, x1, x2
		prog[0][4] = 32'h0041c2b3; // xor  x5, x3, x4
		prog[0][5] = 32'h00329313; // slli x6, x5, 3
		prog[0][6] = 32'h00302023; // sw   x3, 0(x0)
		prog[0][7] = 32'h00402223; // sw   x4, 4(x0)
		prog[0][8] = 32'h00602423; // sw   x6, 8(x0)
		expect_store(0, 32'h0, 32'h2);
		expect_store(0, 32'h4, 32'h8);
		expect_store(0, 32'h8, 32'h50);
		test_name[1] = "compare and arithmetic shift";
		budget[1] = 30;
		prog[1][0] = 32'h00500093; // addi x1, x0, 5
		prog[1][1] = 32'hffd00113; // addi x2, x0, -3
		prog[1][2] = 32'h40115393; // srai x7, x2, 1
		prog[1][3] = 32'h00112433; // slt  x8, x2, x1
		prog[1][4] = 32'h001134b3; // sltu x9, x2, x1
		prog[1][5] = 32'h0020b533; // sltu x10, x1, x2
		prog[1][6] = 32'h00702023; // sw   x7, 0(x0)
		prog[1][7] = 32'h00802223; // sw   x8, 4(x0)
		prog[1][8] = 32'h00902423; // sw   x9, 8(x0)
		prog[1][9] = 32'h00a02623; // sw   x10, 12(x0)
		expect_store(1, 32'h0, 32'hfffffffe);
		expect_store(1, 32'h4, 32'h1);
		expect_store(1, 32'h8, 32'h0);
		expect_store(1, 32'hc, 32'h1);
		test_name[2] = "lui auipc";
		budget[2] = 20;
		prog[2][0] = 32'h123450b7; // lui   x1, 0x12345
		prog[2][1] = 32'h00001117; // auipc x2, 0x1 at pc 4
		prog[2][2] = 32'h00102023; // sw    x1, 0(x0)
		prog[2][3] = 32'h00202223; // sw    x2, 4(x0)
		expect_store(2, 32'h0, 32'h12345000);
		expect_store(2, 32'h4, 32'h00001004);
		test_name[3] = "load use";
		budget[3] = 20;
		prog[3][0] = 32'h00700093; // addi x1, x0, 7
		prog[3][1] = 32'h04002103; // lw   x2, 64(x0)
		prog[3][2] = 32'h001101b3; // add  x3, x2, x1
		prog[3][3] = 32'h00302023; // sw   x3, 0(x0)
		// Word at 0x40 holds c0de0040
		expect_store(3, 32'h0, 32'hc0de0047);
		exp_reads[3] = 1;
		test_name[4] = "branches";
		budget[4] = 40;
		prog[4][0] = 32'h00100093;  // addi x1, x0, 1
		prog[4][1] = 32'hfff00113;  // addi x2, x0, -1
		prog[4][2] = 32'h00208663;  // beq  x1, x2, +12 not taken
		prog[4][3] = 32'h00102023;  // sw   x1, 0(x0)
		prog[4][4] = 32'h00209663;  // bne  x1, x2, +12 taken
		prog[4][5] = 32'h00202223;  // sw   x2, 4(x0) skipped
		prog[4][6] = 32'h00202423;  // sw   x2, 8(x0) skipped
		prog[4][7] = 32'h00114663;  // blt  x2, x1, +12 taken
		prog[4][8] = 32'h00102623;  // sw   x1, 12(x0) skipped
		prog[4][9] = 32'h00102823;  // sw   x1, 16(x0) skipped
		prog[4][10] = 32'h0020f463; // bgeu x1, x2, +8 not taken
		prog[4][11] = 32'h00202a23; // sw   x2, 20(x0)
		expect_store(4, 32'h0, 32'h1);
		expect_store(4, 32'h14, 32'hffffffff);
		test_name[5] = "jal jalr";
		budget[5] = 30;
		prog[5][0] = 32'h00c000ef; // jal  x1, +12
		prog[5][1] = 32'h02102023; // sw   x1, 32(x0) skipped
		prog[5][2] = 32'h02102223; // sw   x1, 36(x0) skipped
		prog[5][3] = 32'h00102023; // sw   x1, 0(x0)
		prog[5][4] = 32'h014082e7; // jalr x5, 20(x1)
		prog[5][5] = 32'h02102423; // sw   x1, 40(x0) skipped
		prog[5][6] = 32'h00502223; // sw   x5, 4(x0)
		expect_store(5, 32'h0, 32'h4);
		expect_store(5, 32'h4, 32'h14);
	endtask

	task automatic run_test(int t);
		int n;
		// Stores everywhere until the program is loaded
		for (int i = 0; i < 16; i++) begin
			imem[i] = STRAY_STORE;
		end
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		// Core is in reset from here on
		@(negedge clk);
		log_addr.delete();
		log_data.delete();
		reset_writes = 0;
		read_count = 0;
		for (int i = 0; i < 16; i++) begin
			imem[i] = (i < PROG_WORDS) ? prog[t][i] : HALT;
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = dmem_fill(i * 4);
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (budget[t]) @(posedge clk);
		@(negedge clk);
		test_errors = 0;
		check_count("number of stores during reset", reset_writes, 0);
		check_count("number of stores", log_addr.size(), exp_count[t]);
		check_count("number of loads", read_count, exp_reads[t]);
		n = (log_addr.size() < exp_count[t]) ? log_addr.size() : exp_count[t];
		for (int i = 0; i < n; i++) begin
			check_word($sformatf("dmem_addr[%0d]", i), log_addr[i], exp_addr[t][i]);
			check_word($sformatf("dmem_wdata[%0d]", i), log_data[i], exp_data[t][i]);
		end
	endtask

	initial begin
		reset = 1'b1;
		errors = 0;
		passed = 0;
		reset_writes = 0;
		read_count = 0;
		for (int i = 0; i < 16; i++) begin
			imem[i] = HALT;
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = dmem_fill(i * 4);
		end
		build_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			watchdog_ns = watchdog_ns + 2 * budget[t] * 10;
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
			if (test_errors == 0) begin
				passed++;
				$display("Test %0d (%s): ok", t, test_name[t]);
			end else begin
				$display("Test %0d (%s): %0d errors", t, test_name[t], test_errors);
			end
			errors = errors + test_errors;
		end
		$display("%0d tests, %0d passed, %0d failed", NUM_TESTS, passed, NUM_TESTS - passed);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* src.f */
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/pipe_stage_reg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/rv_core.sv
verification/rv_core_tb.sv
